/* src/display_pkg.sv */
package display_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stream and settings types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_t;

    typedef struct packed {
        logic [10:0] board_xpos;
        logic [10:0] board_ypos;
        logic [5:0]  button_size;
        logic [4:0]  button_num;
        logic [9:0]  board_size;
    } game_set_t;

    typedef enum logic [1:0] {
        LVL_EASY,
        LVL_MEDIUM,
        LVL_HARD
    } level_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Colours and SVGA timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [11:0] BG_COLOUR    = 12'h125; // Dark blue.
    localparam logic [11:0] BOARD_COLOUR = 12'h999;
    localparam logic [11:0] GRID_COLOUR  = 12'hfff;
    localparam logic [11:0] RED          = 12'hf00;
    localparam logic [11:0] BLACK        = 12'h000;

    localparam logic [10:0] H_VISIBLE    = 11'd800;
    localparam logic [10:0] H_SYNC_START = 11'd840;
    localparam logic [10:0] H_SYNC_END   = 11'd968;
    localparam logic [10:0] H_TOTAL      = 11'd1056;
    localparam logic [10:0] V_VISIBLE    = 11'd600;
    localparam logic [10:0] V_SYNC_START = 11'd601;
    localparam logic [10:0] V_SYNC_END   = 11'd605;
    localparam logic [10:0] V_TOTAL      = 11'd628;

    localparam logic [4:0] EASY_NUM    = 5'd8;
    localparam logic [5:0] EASY_SIZE   = 6'd32;
    localparam logic [4:0] MEDIUM_NUM  = 5'd10;
    localparam logic [5:0] MEDIUM_SIZE = 6'd24;
    localparam logic [4:0] HARD_NUM    = 5'd16;
    localparam logic [5:0] HARD_SIZE   = 6'd16;

endpackage

/* src/vga_timing.sv */
module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output display_pkg::vga_t vga
);

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        hsync_nxt;
    logic        vsync_nxt;
    logic        hblnk_nxt;
    logic        vblnk_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        hcount_nxt = vga.hcount + 11'd1;
        vcount_nxt = vga.vcount;
        if (vga.hcount == display_pkg::H_TOTAL - 11'd1) begin
            hcount_nxt = '0;
            if (vga.vcount == display_pkg::V_TOTAL - 11'd1) begin
                vcount_nxt = '0; // Frame wrap.
            end else begin
                vcount_nxt = vga.vcount + 11'd1;
            end
        end
    end

    // Decoded from the next counts so they line up with the registered counts.
    always_comb begin
        hsync_nxt = (hcount_nxt >= display_pkg::H_SYNC_START) &&
                    (hcount_nxt < display_pkg::H_SYNC_END);
        vsync_nxt = (vcount_nxt >= display_pkg::V_SYNC_START) &&
                    (vcount_nxt < display_pkg::V_SYNC_END);
        hblnk_nxt = (hcount_nxt >= display_pkg::H_VISIBLE);
        vblnk_nxt = (vcount_nxt >= display_pkg::V_VISIBLE);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            vga <= '0;
        end else begin
            vga.hcount <= hcount_nxt;
            vga.vcount <= vcount_nxt;
            vga.hsync  <= hsync_nxt;
            vga.vsync  <= vsync_nxt;
            vga.hblnk  <= hblnk_nxt;
            vga.vblnk  <= vblnk_nxt;
            vga.rgb    <= '0; // Stages downstream paint.
        end
    end

endmodule

/* src/game_settings.sv */
module game_settings (
    input  logic                   clk,
    input  logic                   rst,
    input  display_pkg::level_t    level,
    input  logic                   frame_start,
    output display_pkg::game_set_t gset
);

    logic [4:0]  num;
    logic [5:0]  size;
    logic [9:0]  bsize;
    logic [10:0] xpos;
    logic [10:0] ypos;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Level lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (level)
            display_pkg::LVL_MEDIUM: begin
                num  = display_pkg::MEDIUM_NUM;
                size = display_pkg::MEDIUM_SIZE;
            end
            display_pkg::LVL_HARD: begin
                num  = display_pkg::HARD_NUM;
                size = display_pkg::HARD_SIZE;
            end
            default: begin
                num  = display_pkg::EASY_NUM;
                size = display_pkg::EASY_SIZE;
            end
        endcase
    end

    assign bsize = num * size;
    assign xpos  = (display_pkg::H_VISIBLE - {1'b0, bsize}) >> 1; // Centred.
    assign ypos  = (display_pkg::V_VISIBLE - {1'b0, bsize}) >> 1;

    // Geometry only moves at the top of a frame.
    always_ff @(posedge clk) begin
        if (rst) begin
            gset <= '0;
        end else if (frame_start) begin
            gset.board_xpos  <= xpos;
            gset.board_ypos  <= ypos;
            gset.button_size <= size;
            gset.button_num  <= num;
            gset.board_size  <= bsize;
        end
    end

endmodule

/* src/draw_board.sv */
module draw_board (
    input  logic                   clk,
    input  logic                   rst,
    input  display_pkg::game_set_t gset,
    input  display_pkg::vga_t      in,
    output display_pkg::vga_t      out
);

    logic [5:0]  lx_q;
    logic [5:0]  ly_q;
    logic [5:0]  lx;
    logic [5:0]  ly;
    logic [5:0]  last;
    logic [10:0] board_xend;
    logic [10:0] board_yend;
    logic        in_board;
    logic [11:0] rgb_nxt;

    assign last       = gset.button_size - 6'd1;
    assign board_xend = gset.board_xpos + {1'b0, gset.board_size};
    assign board_yend = gset.board_ypos + {1'b0, gset.board_size};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cell-local position and colour
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        lx = (in.hcount == gset.board_xpos) ? 6'd0 : lx_q; // Restart at left edge.
        ly = (in.vcount == gset.board_ypos) ? 6'd0 : ly_q;
        in_board = (in.hcount >= gset.board_xpos) && (in.hcount < board_xend) &&
                   (in.vcount >= gset.board_ypos) && (in.vcount < board_yend);

        if (in.hblnk || in.vblnk) begin
            rgb_nxt = '0;
        end else if (!in_board) begin
            rgb_nxt = display_pkg::BG_COLOUR;
        end else if ((lx == 6'd0) || (ly == 6'd0)) begin
            rgb_nxt = display_pkg::GRID_COLOUR; // Cell border.
        end else begin
            rgb_nxt = display_pkg::BOARD_COLOUR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lx_q <= '0;
            ly_q <= '0;
            out  <= '0;
        end else begin
            lx_q <= (lx == last) ? 6'd0 : lx + 6'd1;
            if (in.hcount == display_pkg::H_VISIBLE - 11'd1) begin
                ly_q <= (ly == last) ? 6'd0 : ly + 6'd1; // Once per line.
            end
            out     <= in;
            out.rgb <= rgb_nxt;
        end
    end

endmodule

/* src/edge_ctr.sv */
module edge_ctr (
    input  logic       clk,
    input  logic       rst,
    input  logic       clear,
    input  logic       signal,
    input  logic [4:0] max,
    output logic [4:0] ctr_out
);

    logic signal_d;
    logic rise;

    assign rise = signal && !signal_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            signal_d <= 1'b0;
            ctr_out  <= '0;
        end else begin
            signal_d <= signal;
            if (clear) begin
                ctr_out <= '0;
            end else if (rise && (ctr_out < max)) begin
                ctr_out <= ctr_out + 5'd1; // Saturates at max.
            end
        end
    end

endmodule

/* src/draw_flag.sv */
module draw_flag (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [7:0][7:0]        flag_arr_easy,
    input  logic [9:0][9:0]        flag_arr_medium,
    input  logic [15:0][15:0]      flag_arr_hard,
    input  display_pkg::level_t    level,
    input  display_pkg::game_set_t gset,
    input  display_pkg::vga_t      in,
    output display_pkg::vga_t      out,
    output logic [9:0]             board_size
);

    logic [4:0]  col;
    logic [4:0]  row;
    logic        done_x;
    logic        done_y;
    logic [10:0] size;
    logic [10:0] half;
    logic [10:0] cell_xpos;
    logic [10:0] cell_ypos;
    logic [10:0] cur_x;
    logic [10:0] cur_y;
    logic        in_board;
    logic        flagged;
    logic        pole;
    logic        base;
    logic [11:0] rgb_nxt;

    display_pkg::level_t level_d;
    display_pkg::level_t level_act;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cell tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign size      = {5'd0, gset.button_size};
    assign half      = {6'd0, gset.button_size[5:1]};
    assign cell_xpos = gset.board_xpos + col * gset.button_size;
    assign cell_ypos = gset.board_ypos + row * gset.button_size;
    assign cur_x     = in.hcount - cell_xpos;
    assign cur_y     = in.vcount - cell_ypos;

    assign done_x = (cur_x == size - 11'd1); // Last pixel of a cell.
    assign done_y = (cur_y == size - 11'd1) &&
                    (in.hcount == display_pkg::H_VISIBLE - 11'd1);

    assign in_board = (col < gset.button_num) && (row < gset.button_num) &&
                      (in.hcount >= gset.board_xpos) && (in.vcount >= gset.board_ypos);

    edge_ctr x_counter (
        .clk     (clk),
        .rst     (rst),
        .clear   (in.hblnk),
        .signal  (done_x),
        .max     (gset.button_num),
        .ctr_out (col)
    );

    edge_ctr y_counter (
        .clk     (clk),
        .rst     (rst),
        .clear   (in.vblnk),
        .signal  (done_y),
        .max     (gset.button_num),
        .ctr_out (row)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flag overlay
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        flagged = 1'b0;
        if (in_board) begin
            case (level_act)
                display_pkg::LVL_MEDIUM: flagged = flag_arr_medium[col[3:0]][row[3:0]];
                display_pkg::LVL_HARD:   flagged = flag_arr_hard[col[3:0]][row[3:0]];
                default:                 flagged = flag_arr_easy[col[2:0]][row[2:0]];
            endcase
        end
    end

    assign pole = (cur_x >= half) && (cur_x < half + 11'd2) &&
                  (cur_y >= 11'd4) && (cur_y < size - 11'd6);
    assign base = (cur_x >= half - 11'd6) && (cur_x < half + 11'd8) &&
                  (cur_y >= size - 11'd6) && (cur_y < size - 11'd3);

    always_comb begin
        rgb_nxt = in.rgb;
        if (flagged) begin
            if ((cur_x >= 11'd4) && (cur_x < half) && (cur_y >= 11'd4) && (cur_y < half)) begin
                rgb_nxt = display_pkg::RED; // Pennant.
            end else if (pole || base) begin
                rgb_nxt = display_pkg::BLACK;
            end
        end
    end

    // Level is delayed one cycle to match the frame start seen by the settings.
    always_ff @(posedge clk) begin
        if (rst) begin
            out        <= '0;
            board_size <= '0;
            level_d    <= display_pkg::LVL_EASY;
            level_act  <= display_pkg::LVL_EASY;
        end else begin
            out        <= in;
            out.rgb    <= rgb_nxt;
            board_size <= gset.board_size;
            level_d    <= level;
            if ((in.hcount == 11'd0) && (in.vcount == 11'd0)) begin
                level_act <= level_d;
            end
        end
    end

endmodule

/* src/minesweeper_display.sv */
module minesweeper_display (
    input  logic                clk,
    input  logic                rst,
    input  display_pkg::level_t level,
    input  logic [7:0][7:0]     flag_arr_easy,
    input  logic [9:0][9:0]     flag_arr_medium,
    input  logic [15:0][15:0]   flag_arr_hard,
    output display_pkg::vga_t   vga_out,
    output logic [9:0]          board_size
);

    display_pkg::vga_t      t_out;
    display_pkg::vga_t      b_out;
    display_pkg::game_set_t gset;
    logic                   frame_start;

    assign frame_start = (t_out.hcount == 11'd0) && (t_out.vcount == 11'd0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .vga (t_out)
    );

    game_settings u_game_settings (
        .clk         (clk),
        .rst         (rst),
        .level       (level),
        .frame_start (frame_start),
        .gset        (gset)
    );

    draw_board u_draw_board (
        .clk  (clk),
        .rst  (rst),
        .gset (gset),
        .in   (t_out),
        .out  (b_out)
    );

    draw_flag u_draw_flag (
        .clk             (clk),
        .rst             (rst),
        .flag_arr_easy   (flag_arr_easy),
        .flag_arr_medium (flag_arr_medium),
        .flag_arr_hard   (flag_arr_hard),
        .level           (level),
        .gset            (gset),
        .in              (b_out),
        .out             (vga_out),
        .board_size      (board_size)
    );

endmodule

/* verif/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verif/display_tb.sv */
module display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME = display_pkg::H_TOTAL * display_pkg::V_TOTAL;
    localparam int LIMIT = 6 * FRAME + 4000; // Reset and pipeline fill in the margin.

    logic                clk;
    logic                rst;
    display_pkg::level_t level;
    logic [7:0][7:0]     flag_arr_easy;
    logic [9:0][9:0]     flag_arr_medium;
    logic [15:0][15:0]   flag_arr_hard;
    display_pkg::vga_t   vga_out;
    logic [9:0]          board_size;

    logic [31:0]         lfsr = 32'hec178ff4;
    display_pkg::level_t frame_lvl = display_pkg::LVL_EASY;
    logic                checking = 1'b0;
    logic [10:0]         eh = '0;
    logic [10:0]         ev = '0;
    int                  errors = 0;
    int                  prints = 0;
    int                  cycles = 0;
    int                  tests = 0;
    int                  bad_tests = 0;
    int                  mark = 0;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    minesweeper_display DUT (
        .clk             (clk),
        .rst             (rst),
        .level           (level),
        .flag_arr_easy   (flag_arr_easy),
        .flag_arr_medium (flag_arr_medium),
        .flag_arr_hard   (flag_arr_hard),
        .vga_out         (vga_out),
        .board_size      (board_size)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int level_num(input display_pkg::level_t lvl);
        case (lvl)
            display_pkg::LVL_MEDIUM: return display_pkg::MEDIUM_NUM;
            display_pkg::LVL_HARD:   return display_pkg::HARD_NUM;
            default:                 return display_pkg::EASY_NUM;
        endcase
    endfunction

    function automatic int level_size(input display_pkg::level_t lvl);
        case (lvl)
            display_pkg::LVL_MEDIUM: return display_pkg::MEDIUM_SIZE;
            display_pkg::LVL_HARD:   return display_pkg::HARD_SIZE;
            default:                 return display_pkg::EASY_SIZE;
        endcase
    endfunction

    function automatic logic [11:0] pixel_ref(input int h, input int v,
                                              input display_pkg::level_t lvl,
                                              input logic [7:0][7:0] fe,
                                              input logic [9:0][9:0] fm,
                                              input logic [15:0][15:0] fh);
        int          size;
        int          bsize;
        int          xpos;
        int          ypos;
        int          col;
        int          row;
        int          x;
        int          y;
        int          half;
        logic        flag;
        logic [11:0] c;
        size  = level_size(lvl);
        bsize = level_num(lvl) * size;
        xpos  = (800 - bsize) / 2;
        ypos  = (600 - bsize) / 2;
        half  = size / 2;
        if (h >= 800 || v >= 600) return 12'h000;
        if (h < xpos || h >= xpos + bsize || v < ypos || v >= ypos + bsize) begin
            return display_pkg::BG_COLOUR;
        end
        col = (h - xpos) / size;
        row = (v - ypos) / size;
        x   = (h - xpos) % size;
        y   = (v - ypos) % size;
        c   = (x == 0 || y == 0) ? display_pkg::GRID_COLOUR : display_pkg::BOARD_COLOUR;
        case (lvl)
            display_pkg::LVL_MEDIUM: flag = fm[col][row];
            display_pkg::LVL_HARD:   flag = fh[col][row];
            default:                 flag = fe[col][row];
        endcase
        if (flag) begin
            if (x >= 4 && x < half && y >= 4 && y < half) begin
                c = display_pkg::RED; // Pennant.
            end else if ((x >= half && x < half + 2 && y >= 4 && y < size - 6) ||
                         (x >= half - 6 && x < half + 8 && y >= size - 6 && y < size - 3)) begin
                c = display_pkg::BLACK;
            end
        end
        return c;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_vga(input display_pkg::vga_t got, input display_pkg::vga_t exp);
        if (got !== exp) begin
            errors++;
            if (prints < 20) begin
                prints++;
                $display("FAIL %0t: vga_out at h=%0d v=%0d is %h, expected %h",
                         $time, exp.hcount, exp.vcount, got, exp);
            end
        end
    endtask

    task automatic check_size(input logic [9:0] got, input logic [9:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: board_size is %0d, expected %0d", $time, got, exp);
        end
    endtask

    // Compares every output pixel against the model, two cycles behind the generator.
    always @(negedge clk) begin
        display_pkg::vga_t exp;
        if (checking) begin
            exp.hcount = eh;
            exp.vcount = ev;
            exp.hsync  = (eh >= display_pkg::H_SYNC_START) && (eh < display_pkg::H_SYNC_END);
            exp.vsync  = (ev >= display_pkg::V_SYNC_START) && (ev < display_pkg::V_SYNC_END);
            exp.hblnk  = (eh >= display_pkg::H_VISIBLE);
            exp.vblnk  = (ev >= display_pkg::V_VISIBLE);
            exp.rgb    = pixel_ref(eh, ev, frame_lvl, flag_arr_easy, flag_arr_medium,
                                   flag_arr_hard);
            check_vga(vga_out, exp);
            if (eh == 11'd400 && ev == 11'd300) begin
                check_size(board_size, 10'(level_num(frame_lvl) * level_size(frame_lvl)));
            end
            // Generator is at the frame origin now, so this level rules the next frame.
            if (eh == display_pkg::H_TOTAL - 11'd2 && ev == display_pkg::V_TOTAL - 11'd1) begin
                frame_lvl = level;
            end
            if (eh == display_pkg::H_TOTAL - 11'd1) begin
                eh = '0;
                ev = (ev == display_pkg::V_TOTAL - 11'd1) ? 11'd0 : ev + 11'd1;
            end else begin
                eh = eh + 11'd1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_pixel(input logic [10:0] h, input logic [10:0] v);
        do begin
            @(negedge clk);
        end while (!(vga_out.hcount == h && vga_out.vcount == v));
    endtask

    task automatic fill_flags();
        logic [419:0] bits; // Easy, medium, then hard bits from the low end.
        for (int i = 0; i < 420; i++) begin
            random_bit(bits[i]);
        end
        @(posedge clk);
        flag_arr_easy   <= bits[63:0];
        flag_arr_medium <= bits[163:64];
        flag_arr_hard   <= bits[419:164];
    endtask

    task automatic report(input string name);
        tests++;
        if (errors != mark) bad_tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - mark);
        mark = errors;
    endtask

    task automatic finish_frame(input string name);
        wait_pixel(display_pkg::H_TOTAL - 11'd1, display_pkg::V_TOTAL - 11'd1);
        @(posedge clk);
        report(name);
    endtask

    initial begin
        level           = display_pkg::LVL_EASY;
        flag_arr_easy   = '0;
        flag_arr_medium = '0;
        flag_arr_hard   = '0;

        @(negedge clk);
        while (rst) begin
            check_vga(vga_out, '0);
            check_size(board_size, '0);
            @(negedge clk);
        end
        check_vga(vga_out, '0); // Pipeline still holds reset values.
        check_size(board_size, '0);
        @(negedge clk);
        check_vga(vga_out, '0);
        check_size(board_size, '0);
        @(posedge clk);
        checking = 1'b1; // Origin pixel is on vga_out at the next falling edge.
        report("reset values");

        wait_pixel(11'd0, 11'd610);
        fill_flags();
        finish_frame("easy, flags clear, sync and board");

        wait_pixel(11'd0, 11'd610);
        @(posedge clk);
        level <= display_pkg::LVL_MEDIUM;
        fill_flags();
        finish_frame("easy, random flags");

        wait_pixel(11'd0, 11'd610);
        @(posedge clk);
        level <= display_pkg::LVL_HARD;
        fill_flags();
        finish_frame("medium, random flags");

        wait_pixel(11'd0, 11'd610);
        fill_flags();
        finish_frame("hard, random flags");

        wait_pixel(11'd0, 11'd200);
        @(posedge clk);
        level <= display_pkg::LVL_MEDIUM; // Mid-frame switch.
        finish_frame("level change keeps old geometry");

        finish_frame("new geometry next frame");

        $display("tests run %0d, with errors %0d, error count %0d", tests, bad_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
src/display_pkg.sv
src/vga_timing.sv
src/game_settings.sv
src/draw_board.sv
src/edge_ctr.sv
src/draw_flag.sv
src/minesweeper_display.sv
verif/clk_gen.sv
verif/display_tb.sv
